// File: hw/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int ADDR_BITS   = 32;
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 5;
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    // default depth of the memory model, in lines
    localparam int MEM_LINES = 256;

    // address fields
    typedef logic [ADDR_BITS-1:0]            addr_t;
    typedef logic [OFFSET_BITS-1:0]          offset_t;
    typedef logic [INDEX_BITS-1:0]           index_t;
    typedef logic [TAG_BITS-1:0]             tag_t;

    // tag and index together address one line
    typedef logic [TAG_BITS+INDEX_BITS-1:0]  line_addr_t;

    // payloads
    typedef logic [LINE_BYTES*8-1:0]         line_t;
    typedef logic [7:0]                      byte_t;

    // request FSM of the cache controller
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        LOOKUP    = 2'd1,
        WRITEBACK = 2'd2,
        ALLOCATE  = 2'd3
    } ctrl_state_t;

endpackage

// File: hw/mem_bus_if.sv
interface mem_bus_if;
    import cache_pkg::*;

    // write address, write data, write response
    logic       aw_valid, aw_ready;
    line_addr_t aw_addr;
    logic       w_valid, w_ready;
    line_t      w_data;
    logic       b_valid, b_ready;

    // read address, read data
    logic       ar_valid, ar_ready;
    line_addr_t ar_addr;
    logic       r_valid, r_ready;
    line_t      r_data;

    modport master (
        output aw_valid, aw_addr, w_valid, w_data, b_ready, ar_valid, ar_addr, r_ready,
        input  aw_ready, w_ready, b_valid, ar_ready, r_valid, r_data
    );

    modport slave (
        input  aw_valid, aw_addr, w_valid, w_data, b_ready, ar_valid, ar_addr, r_ready,
        output aw_ready, w_ready, b_valid, ar_ready, r_valid, r_data
    );

endinterface

// File: hw/cache_ctrl.sv
module cache_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    input  logic cpu_write,
    input  logic line_hit,
    input  logic victim_dirty,
    input  logic mem_done,
    output logic do_write,
    output logic do_fill,
    output logic start_read,
    output logic start_write,
    output logic cpu_done,
    output logic cpu_hit
);
    import cache_pkg::*;

    ctrl_state_t state, next_state;
    // set once the first lookup of a request misses
    logic        missed;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= IDLE;
            missed      <= 1'b0;
            start_read  <= 1'b0;
            start_write <= 1'b0;
        end else begin
            state <= next_state;
            if (state == IDLE && cpu_req) begin
                missed <= 1'b0;
            end else if (state == LOOKUP && !line_hit) begin
                missed <= 1'b1;
            end
            // bus master kicked once on state entry
            start_read  <= (next_state == ALLOCATE) && (state != ALLOCATE);
            start_write <= (next_state == WRITEBACK) && (state != WRITEBACK);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cpu_req) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (line_hit) begin
                    next_state = IDLE;
                end else if (victim_dirty) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (mem_done) next_state = ALLOCATE;
            end
            ALLOCATE: begin
                // line is filled in this cycle, lookup again to finish
                if (mem_done) next_state = LOOKUP;
            end
            default: next_state = IDLE;
        endcase
    end

    assign cpu_done = (state == LOOKUP) && line_hit;
    assign cpu_hit  = !missed;
    assign do_write = cpu_done && cpu_write;
    assign do_fill  = (state == ALLOCATE) && mem_done;

    // bus master answers only while a memory request waits on it
    a_mem_done_state: assert property (@(posedge clk) disable iff (!reset)
        mem_done |-> (state == WRITEBACK || state == ALLOCATE));
    // a freshly filled line hits on the lookup that follows
    a_fill_hits: assert property (@(posedge clk) disable iff (!reset)
        do_fill |=> line_hit);

endmodule

// File: hw/cache_array.sv
module cache_array #(
    parameter int num_lines = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::addr_t      cpu_addr,
    input  cache_pkg::byte_t      cpu_wdata,
    input  logic                  do_write,
    input  logic                  do_fill,
    input  cache_pkg::line_t      fill_data,
    output logic                  line_hit,
    output logic                  victim_dirty,
    output cache_pkg::line_addr_t victim_addr,
    output cache_pkg::line_t      victim_data,
    output cache_pkg::byte_t      cpu_rdata
);
    import cache_pkg::*;

    tag_t                 tag_mem  [num_lines];
    line_t                data_mem [num_lines];
    logic [num_lines-1:0] valid_q;
    logic [num_lines-1:0] dirty_q;

    tag_t    tag;
    index_t  idx;
    offset_t off;

    assign tag = cpu_addr[ADDR_BITS-1 -: TAG_BITS];
    assign idx = cpu_addr[OFFSET_BITS +: INDEX_BITS];
    assign off = cpu_addr[OFFSET_BITS-1:0];

    assign line_hit     = valid_q[idx] && (tag_mem[idx] == tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];
    assign victim_addr  = {tag_mem[idx], idx};
    assign victim_data  = data_mem[idx];

    // a write answers with the byte it stores
    assign cpu_rdata = do_write ? cpu_wdata : data_mem[idx][{off, 3'b000} +: 8];

    // line state bits
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (do_fill) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end else if (do_write) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (do_fill) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= fill_data;
        end else if (do_write) begin
            data_mem[idx][{off, 3'b000} +: 8] <= cpu_wdata;
        end
    end

    a_one_update: assert property (@(posedge clk) disable iff (!reset)
        !(do_write && do_fill));

endmodule

// File: hw/axi_master.sv
module axi_master (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_write,
    input  logic                  start_read,
    input  cache_pkg::line_addr_t victim_addr,
    input  cache_pkg::line_t      victim_data,
    input  cache_pkg::line_addr_t fill_addr,
    output logic                  mem_done,
    output cache_pkg::line_t      fill_data,
    mem_bus_if.master             bus
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_WADDR = 3'd1,
        ST_WDATA = 3'd2,
        ST_BRESP = 3'd3,
        ST_RADDR = 3'd4,
        ST_RDATA = 3'd5
    } axi_state_t;

    axi_state_t state, next_state;
    line_addr_t addr_q;
    line_t      data_q;
    logic       b_fire, r_fire;

    assign b_fire = bus.b_valid && bus.b_ready;
    assign r_fire = bus.r_valid && bus.r_ready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= ST_IDLE;
            mem_done <= 1'b0;
        end else begin
            state    <= next_state;
            mem_done <= b_fire || r_fire;
        end
    end

    // address and line held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_write) begin
            addr_q <= victim_addr;
            data_q <= victim_data;
        end else if (state == ST_IDLE && start_read) begin
            addr_q <= fill_addr;
        end
        if (r_fire) fill_data <= bus.r_data;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start_write) begin
                    next_state = ST_WADDR;
                end else if (start_read) begin
                    next_state = ST_RADDR;
                end
            end
            ST_WADDR: if (bus.aw_ready) next_state = ST_WDATA;
            ST_WDATA: if (bus.w_ready)  next_state = ST_BRESP;
            ST_BRESP: if (bus.b_valid)  next_state = ST_IDLE;
            ST_RADDR: if (bus.ar_ready) next_state = ST_RDATA;
            ST_RDATA: if (bus.r_valid)  next_state = ST_IDLE;
            default:  next_state = ST_IDLE;
        endcase
    end

    assign bus.aw_valid = (state == ST_WADDR);
    assign bus.w_valid  = (state == ST_WDATA);
    assign bus.b_ready  = (state == ST_BRESP);
    assign bus.ar_valid = (state == ST_RADDR);
    assign bus.r_ready  = (state == ST_RDATA);
    assign bus.aw_addr  = addr_q;
    assign bus.ar_addr  = addr_q;
    assign bus.w_data   = data_q;

    // memory raises a ready only for an address still held valid
    a_aw_ready: assert property (@(posedge clk) disable iff (!reset)
        bus.aw_ready |-> bus.aw_valid);
    a_ar_ready: assert property (@(posedge clk) disable iff (!reset)
        bus.ar_ready |-> bus.ar_valid);

endmodule

// File: hw/main_memory.sv
module main_memory #(
    parameter int mem_latency = 3,
    parameter int mem_lines   = 256
) (
    input logic      clk,
    input logic      reset,
    mem_bus_if.slave bus
);
    import cache_pkg::*;

    localparam int MIDX_W = $clog2(mem_lines);
    localparam int CNT_W  = $clog2(mem_latency + 1);

    line_t      mem [mem_lines];
    line_addr_t waddr_q, raddr_q;
    logic [CNT_W-1:0] cnt;
    logic       b_pend, r_pend;
    logic       aw_wait, w_wait, ar_wait, b_wait, r_wait;
    logic       pending, fire;

    // phases follow one another, so one counter serves each in turn
    assign aw_wait = bus.aw_valid && !bus.aw_ready;
    assign w_wait  = bus.w_valid && !bus.w_ready;
    assign ar_wait = bus.ar_valid && !bus.ar_ready;
    assign b_wait  = b_pend && !bus.b_valid;
    assign r_wait  = r_pend && !bus.r_valid;
    assign pending = aw_wait || w_wait || ar_wait || b_wait || r_wait;
    assign fire    = pending && (cnt == CNT_W'(mem_latency - 1));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt          <= '0;
            b_pend       <= 1'b0;
            r_pend       <= 1'b0;
            bus.aw_ready <= 1'b0;
            bus.w_ready  <= 1'b0;
            bus.ar_ready <= 1'b0;
            bus.b_valid  <= 1'b0;
            bus.r_valid  <= 1'b0;
            for (int i = 0; i < mem_lines; i++) mem[i] <= '0;
        end else begin
            if (fire) begin
                cnt <= '0;
            end else if (pending) begin
                cnt <= cnt + 1'b1;
            end
            // readies last one cycle, the master holds valid
            bus.aw_ready <= fire && aw_wait;
            bus.w_ready  <= fire && w_wait;
            bus.ar_ready <= fire && ar_wait;
            if (bus.w_valid && bus.w_ready) begin
                mem[waddr_q[MIDX_W-1:0]] <= bus.w_data;
                b_pend <= 1'b1;
            end
            if (fire && b_wait) begin
                bus.b_valid <= 1'b1;
            end else if (bus.b_valid && bus.b_ready) begin
                bus.b_valid <= 1'b0;
                b_pend      <= 1'b0;
            end
            if (bus.ar_valid && bus.ar_ready) r_pend <= 1'b1;
            if (fire && r_wait) begin
                bus.r_valid <= 1'b1;
            end else if (bus.r_valid && bus.r_ready) begin
                bus.r_valid <= 1'b0;
                r_pend      <= 1'b0;
            end
        end
    end

    // addresses and read line
    always_ff @(posedge clk) begin
        if (bus.aw_valid && bus.aw_ready) waddr_q <= bus.aw_addr;
        if (bus.ar_valid && bus.ar_ready) raddr_q <= bus.ar_addr;
        if (fire && r_wait) bus.r_data <= mem[raddr_q[MIDX_W-1:0]];
    end

endmodule

// File: hw/cache_top.sv
module cache_top #(
    parameter int num_lines   = 2 ** cache_pkg::INDEX_BITS,
    parameter int mem_latency = 3,
    parameter int mem_lines   = cache_pkg::MEM_LINES
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cpu_req,
    input  logic             cpu_write,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::byte_t cpu_wdata,
    output cache_pkg::byte_t cpu_rdata,
    output logic             cpu_done,
    output logic             cpu_hit
);
    import cache_pkg::*;

    logic       line_hit, victim_dirty;
    logic       do_write, do_fill;
    logic       start_read, start_write, mem_done;
    line_addr_t victim_addr, fill_addr;
    line_t      victim_data, fill_data;

    mem_bus_if bus ();

    // line address of the request
    assign fill_addr = cpu_addr[ADDR_BITS-1:OFFSET_BITS];

    cache_ctrl i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_write    (cpu_write),
        .line_hit     (line_hit),
        .victim_dirty (victim_dirty),
        .mem_done     (mem_done),
        .do_write     (do_write),
        .do_fill      (do_fill),
        .start_read   (start_read),
        .start_write  (start_write),
        .cpu_done     (cpu_done),
        .cpu_hit      (cpu_hit)
    );

    cache_array #(.num_lines(num_lines)) i_array (
        .clk          (clk),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .do_write     (do_write),
        .do_fill      (do_fill),
        .fill_data    (fill_data),
        .line_hit     (line_hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_data  (victim_data),
        .cpu_rdata    (cpu_rdata)
    );

    axi_master i_master (
        .clk         (clk),
        .reset       (reset),
        .start_write (start_write),
        .start_read  (start_read),
        .victim_addr (victim_addr),
        .victim_data (victim_data),
        .fill_addr   (fill_addr),
        .mem_done    (mem_done),
        .fill_data   (fill_data),
        .bus         (bus.master)
    );

    main_memory #(
        .mem_latency (mem_latency),
        .mem_lines   (mem_lines)
    ) i_memory (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.slave)
    );

endmodule

// File: verification/cache_tb.sv
module cache_tb;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int HIT_LATENCY    = 1;

    logic  clk;
    logic  reset;
    logic  cpu_req;
    logic  cpu_write;
    addr_t cpu_addr;
    byte_t cpu_wdata;
    byte_t cpu_rdata;
    logic  cpu_done;
    logic  cpu_hit;

    int    fd;
    int    code;
    int    tests;
    int    passed;
    int    errors;
    int    test_errors;
    int    cycles;
    logic  timed_out;
    logic  done_seen;
    string line_s;
    string test_name;
    logic [7:0] op;
    addr_t addr;
    byte_t wdata;
    byte_t exp_rdata;
    logic  exp_hit;
    byte_t got_rdata;
    logic  got_hit;

    cache_top #(
        .mem_latency (3)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_write (cpu_write),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_done  (cpu_done),
        .cpu_hit   (cpu_hit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one CPU request, called on a falling edge; holds req until cpu_done
    task automatic issue_request(input logic write, input addr_t a, input byte_t wd,
                                 output int wait_cycles, output logic seen,
                                 output byte_t rdata, output logic hit);
        wait_cycles = 0;
        seen        = 1'b0;
        rdata       = '0;
        hit         = 1'b0;
        cpu_req     = 1'b1;
        cpu_write   = write;
        cpu_addr    = a;
        cpu_wdata   = wd;
        while (!seen && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
            seen = cpu_done;
        end
        rdata   = cpu_rdata;
        hit     = cpu_hit;
        cpu_req = 1'b0;
        // request line low for one cycle before the next one
        @(negedge clk);
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    initial begin
        reset     = 1'b0;
        cpu_req   = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        tests     = 0;
        passed    = 0;
        errors    = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        fd = $fopen("verification/cache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verification/cache_input.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line_s, fd) != 0) begin
                if (line_s.len() == 0 || line_s.getc(0) == "#") continue;
                code = $sscanf(line_s, "%c %h %h %h %h", op, addr, wdata, exp_rdata, exp_hit);
                if (code != 5) continue;
                tests++;
                test_errors = 0;
                test_name = $sformatf("test %0d (%c %h)", tests, op, addr);
                issue_request(op == "W", addr, wdata, cycles, done_seen, got_rdata, got_hit);
                assert (done_seen) else begin
                    $display("%s: cpu_done never came within %0d cycles",
                             test_name, TIMEOUT_CYCLES);
                    test_errors++;
                    timed_out = 1'b1;
                end
                if (done_seen) begin
                    compare_value(test_name, "rdata", 32'(exp_rdata), 32'(got_rdata));
                    compare_value(test_name, "hit", 32'(exp_hit), 32'(got_hit));
                    // a hit finishes one cycle after req is sampled
                    if (exp_hit) begin
                        compare_value(test_name, "hit latency", 32'(HIT_LATENCY), 32'(cycles));
                    end
                end
                if (test_errors == 0) begin
                    passed++;
                    $display("%s passed after %0d cycles", test_name, cycles);
                end else begin
                    errors++;
                    $display("%s failed", test_name);
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d", tests, passed, tests - passed);
        if (errors == 0 && tests > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verification/cache_input.txt
# op (R/W), byte address (hex), write byte, expected rdata, expected hit
# index is addr[8:4], so addresses 0x200 apart share a line slot
R 000 00 00 0
W 003 ab ab 1
R 003 00 ab 1
R 000 00 00 1
R 00f 00 00 1
W 024 5c 5c 0
R 024 00 5c 1
R 025 00 00 1
R 200 00 00 0
R 003 00 ab 0
R 000 00 00 1
R 050 00 00 0
R 250 00 00 0
R 050 00 00 0
R 257 00 00 0
W 224 77 77 0
R 024 00 5c 0
R 224 00 77 0
W fff e1 e1 0
R fff 00 e1 1
R ff0 00 00 1

// File: compile.f
hw/cache_pkg.sv
hw/mem_bus_if.sv
hw/cache_ctrl.sv
hw/cache_array.sv
hw/axi_master.sv
hw/main_memory.sv
hw/cache_top.sv
verification/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f compile.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
